//--- design/glb_cfg_pkg.sv
// 12-bit byte address map with bit 11 selecting tile config; sizes are fixed localparams
package glb_cfg_pkg;

    // AXI-lite bus widths
    localparam int AXI_ADDR_WIDTH = 12;
    localparam int AXI_DATA_WIDTH = 32;

    // tile array and its address fields
    localparam int NUM_TILES     = 4;
    localparam int TILE_ID_WIDTH = 2;
    localparam int TILE_ID_LSB   = 8;
    localparam int REGS_PER_TILE = 4;
    localparam int REG_IDX_WIDTH = $clog2(REGS_PER_TILE);
    localparam int REG_IDX_LSB   = 2;

    // top address bit picks the tile block over the interrupt block
    localparam int TILE_SEL_BIT = AXI_ADDR_WIDTH - 1;

    // fixed settle time after a tile write
    localparam int TILE_WR_WAIT  = 16;
    localparam int WR_WAIT_WIDTH = $clog2(TILE_WR_WAIT + 1);

    // interrupt register offsets
    localparam logic [AXI_ADDR_WIDTH-1:0] INT_ENABLE_ADDR  = 12'h000;
    localparam logic [AXI_ADDR_WIDTH-1:0] INT_STATUS_ADDR  = 12'h004;
    localparam logic [AXI_ADDR_WIDTH-1:0] INT_PENDING_ADDR = 12'h008;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [2:0] {
        WR_IDLE          = 3'h0,
        WR_REQ_INTERRUPT = 3'h1,
        WR_REQ_TILE      = 3'h2,
        WR_WAIT          = 3'h3,
        WR_RESP          = 3'h4
    } cfg_wr_state_t;

    typedef enum logic [2:0] {
        RD_IDLE          = 3'h0,
        RD_REQ_INTERRUPT = 3'h1,
        RD_REQ_TILE      = 3'h2,
        RD_WAIT          = 3'h3,
        RD_RESP          = 3'h4
    } cfg_rd_state_t;

endpackage

//--- design/glb_axil_cfg_ctrl.sv
// single-beat AXI-lite only: no bursts or strobes, responses always OKAY, one write and one read
`timescale 1ns/1ps

module glb_axil_cfg_ctrl import glb_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    // AXI-lite slave
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [AXI_DATA_WIDTH-1:0] wdata,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [AXI_ADDR_WIDTH-1:0] araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                rresp,
    // interrupt block config port
    output logic                      int_wr_en,
    output logic [AXI_ADDR_WIDTH-1:0] int_wr_addr,
    output logic [AXI_DATA_WIDTH-1:0] int_wr_data,
    output logic                      int_rd_en,
    output logic [AXI_ADDR_WIDTH-1:0] int_rd_addr,
    input  logic [AXI_DATA_WIDTH-1:0] int_rd_data,
    input  logic                      int_rd_data_valid,
    output logic                      int_wr_clk_en,
    output logic                      int_rd_clk_en,
    // tile block config port
    output logic                      tile_wr_en,
    output logic [AXI_ADDR_WIDTH-1:0] tile_wr_addr,
    output logic [AXI_DATA_WIDTH-1:0] tile_wr_data,
    output logic                      tile_rd_en,
    output logic [AXI_ADDR_WIDTH-1:0] tile_rd_addr,
    input  logic [AXI_DATA_WIDTH-1:0] tile_rd_data,
    input  logic                      tile_rd_data_valid,
    output logic                      tile_wr_clk_en,
    output logic                      tile_rd_clk_en
);

    cfg_wr_state_t             wr_state;
    cfg_rd_state_t             rd_state;
    logic [WR_WAIT_WIDTH-1:0]  wr_wait_cnt;
    logic [AXI_ADDR_WIDTH-1:0] wr_addr_q;
    logic [AXI_DATA_WIDTH-1:0] wr_data_q;
    logic [AXI_ADDR_WIDTH-1:0] rd_addr_q;
    logic                      rd_is_tile;
    logic                      rd_sel_valid;
    logic [AXI_DATA_WIDTH-1:0] rd_sel_data;

    // clock-enable intent, seen by targets half a cycle later
    logic int_wr_clk_en_p;
    logic int_rd_clk_en_p;
    logic tile_wr_clk_en_p;
    logic tile_rd_clk_en_p;

    assign bresp = AXI_RESP_OKAY;
    assign rresp = AXI_RESP_OKAY;

    // both targets share the captured address and data, wr_en/rd_en pick one
    assign int_wr_addr  = wr_addr_q;
    assign tile_wr_addr = wr_addr_q;
    assign int_wr_data  = wr_data_q;
    assign tile_wr_data = wr_data_q;
    assign int_rd_addr  = rd_addr_q;
    assign tile_rd_addr = rd_addr_q;

    // only the target that was asked may answer
    assign rd_is_tile   = rd_addr_q[TILE_SEL_BIT];
    assign rd_sel_valid = rd_is_tile ? tile_rd_data_valid : int_rd_data_valid;
    assign rd_sel_data  = rd_is_tile ? tile_rd_data : int_rd_data;

    always_ff @(posedge clk) begin
        if (wr_state == WR_IDLE && awvalid && awready) begin
            wr_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            wr_data_q <= wdata;
        end
        if (rd_state == RD_IDLE && arvalid && arready) begin
            rd_addr_q <= araddr;
        end
        if (rd_state == RD_WAIT && rd_sel_valid) begin
            rdata <= rd_sel_data;
        end
    end

    // write FSM, w may arrive before, with or after aw
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_state         <= WR_IDLE;
            awready          <= 1'b1;
            wready           <= 1'b1;
            bvalid           <= 1'b0;
            int_wr_en        <= 1'b0;
            tile_wr_en       <= 1'b0;
            wr_wait_cnt      <= '0;
            int_wr_clk_en_p  <= 1'b0;
            tile_wr_clk_en_p <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wvalid && wready) begin
                        wready <= 1'b0;
                    end
                    if (awvalid && awready) begin
                        awready          <= 1'b0;
                        tile_wr_clk_en_p <= awaddr[TILE_SEL_BIT];
                        int_wr_clk_en_p  <= !awaddr[TILE_SEL_BIT];
                        wr_state <= awaddr[TILE_SEL_BIT] ? WR_REQ_TILE : WR_REQ_INTERRUPT;
                    end
                end
                WR_REQ_INTERRUPT, WR_REQ_TILE: begin
                    // wready low here means the data beat is already held
                    if (wvalid || !wready) begin
                        wready     <= 1'b0;
                        int_wr_en  <= (wr_state == WR_REQ_INTERRUPT);
                        tile_wr_en <= (wr_state == WR_REQ_TILE);
                        if (wr_state == WR_REQ_TILE) begin
                            wr_wait_cnt <= WR_WAIT_WIDTH'(TILE_WR_WAIT);
                        end else begin
                            wr_wait_cnt <= '0;
                        end
                        wr_state <= WR_WAIT;
                    end
                end
                WR_WAIT: begin
                    int_wr_en  <= 1'b0;
                    tile_wr_en <= 1'b0;
                    if (wr_wait_cnt == '0) begin
                        bvalid   <= 1'b1;
                        wr_state <= WR_RESP;
                    end else begin
                        wr_wait_cnt <= wr_wait_cnt - 1'b1;
                    end
                end
                WR_RESP: begin
                    if (bready) begin
                        bvalid           <= 1'b0;
                        awready          <= 1'b1;
                        wready           <= 1'b1;
                        int_wr_clk_en_p  <= 1'b0;
                        tile_wr_clk_en_p <= 1'b0;
                        wr_state         <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // read FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_state         <= RD_IDLE;
            arready          <= 1'b1;
            rvalid           <= 1'b0;
            int_rd_en        <= 1'b0;
            tile_rd_en       <= 1'b0;
            int_rd_clk_en_p  <= 1'b0;
            tile_rd_clk_en_p <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arvalid && arready) begin
                        arready          <= 1'b0;
                        tile_rd_clk_en_p <= araddr[TILE_SEL_BIT];
                        int_rd_clk_en_p  <= !araddr[TILE_SEL_BIT];
                        rd_state <= araddr[TILE_SEL_BIT] ? RD_REQ_TILE : RD_REQ_INTERRUPT;
                    end
                end
                RD_REQ_INTERRUPT: begin
                    int_rd_en <= 1'b1;
                    rd_state  <= RD_WAIT;
                end
                RD_REQ_TILE: begin
                    tile_rd_en <= 1'b1;
                    rd_state   <= RD_WAIT;
                end
                RD_WAIT: begin
                    int_rd_en  <= 1'b0;
                    tile_rd_en <= 1'b0;
                    if (rd_sel_valid) begin
                        rvalid   <= 1'b1;
                        rd_state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (rready) begin
                        rvalid           <= 1'b0;
                        arready          <= 1'b1;
                        int_rd_clk_en_p  <= 1'b0;
                        tile_rd_clk_en_p <= 1'b0;
                        rd_state         <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // half-cycle shift so enables settle before the next rising edge
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            int_wr_clk_en  <= 1'b0;
            int_rd_clk_en  <= 1'b0;
            tile_wr_clk_en <= 1'b0;
            tile_rd_clk_en <= 1'b0;
        end else begin
            int_wr_clk_en  <= int_wr_clk_en_p;
            int_rd_clk_en  <= int_rd_clk_en_p;
            tile_wr_clk_en <= tile_wr_clk_en_p;
            tile_rd_clk_en <= tile_rd_clk_en_p;
        end
    end

endmodule

//--- design/glb_interrupt_cfg.sv
// one status bit per tile; events are sampled every cycle, config access needs its clock-enable
`timescale 1ns/1ps

module glb_interrupt_cfg import glb_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_clk_en,
    input  logic                      rd_clk_en,
    input  logic                      wr_en,
    input  logic [AXI_ADDR_WIDTH-1:0] wr_addr,
    input  logic [AXI_DATA_WIDTH-1:0] wr_data,
    input  logic                      rd_en,
    input  logic [AXI_ADDR_WIDTH-1:0] rd_addr,
    input  logic [NUM_TILES-1:0]      interrupt_event,
    output logic [AXI_DATA_WIDTH-1:0] rd_data,
    output logic                      rd_data_valid,
    output logic                      interrupt
);

    logic                 wr_hit;
    logic [NUM_TILES-1:0] int_enable;
    logic [NUM_TILES-1:0] int_status;
    logic [NUM_TILES-1:0] int_pending;
    logic [NUM_TILES-1:0] status_clr;

    assign wr_hit      = wr_clk_en && wr_en;
    assign status_clr  = (wr_hit && wr_addr == INT_STATUS_ADDR) ? wr_data[NUM_TILES-1:0] : '0;
    assign int_pending = int_status & int_enable;
    assign interrupt   = |int_pending;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            int_enable <= '0;
        end else if (wr_hit && wr_addr == INT_ENABLE_ADDR) begin
            int_enable <= wr_data[NUM_TILES-1:0];
        end
    end

    // a new event wins over a clear of the same bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            int_status <= '0;
        end else begin
            int_status <= (int_status & ~status_clr) | interrupt_event;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en && rd_clk_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en && rd_clk_en) begin
            case (rd_addr)
                INT_ENABLE_ADDR:  rd_data <= AXI_DATA_WIDTH'(int_enable);
                INT_STATUS_ADDR:  rd_data <= AXI_DATA_WIDTH'(int_status);
                INT_PENDING_ADDR: rd_data <= AXI_DATA_WIDTH'(int_pending);
                default:          rd_data <= '0;
            endcase
        end
    end

endmodule

//--- design/glb_tile_cfg.sv
// read latency is tile id plus one; only one read may be in the chain at a time
`timescale 1ns/1ps

module glb_tile_cfg import glb_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_clk_en,
    input  logic                      rd_clk_en,
    input  logic                      wr_en,
    input  logic [AXI_ADDR_WIDTH-1:0] wr_addr,
    input  logic [AXI_DATA_WIDTH-1:0] wr_data,
    input  logic                      rd_en,
    input  logic [AXI_ADDR_WIDTH-1:0] rd_addr,
    output logic [AXI_DATA_WIDTH-1:0] rd_data,
    output logic                      rd_data_valid
);

    logic [AXI_DATA_WIDTH-1:0] cfg_mem [NUM_TILES][REGS_PER_TILE];
    logic [TILE_ID_WIDTH-1:0]  wr_tile;
    logic [TILE_ID_WIDTH-1:0]  rd_tile;
    logic [REG_IDX_WIDTH-1:0]  wr_idx;
    logic [REG_IDX_WIDTH-1:0]  rd_idx;
    logic [NUM_TILES-1:0]      load_mask;
    logic [NUM_TILES-1:0]      chain_valid;
    logic [AXI_DATA_WIDTH-1:0] chain_data [NUM_TILES];

    assign wr_tile = wr_addr[TILE_ID_LSB +: TILE_ID_WIDTH];
    assign wr_idx  = wr_addr[REG_IDX_LSB +: REG_IDX_WIDTH];
    assign rd_tile = rd_addr[TILE_ID_LSB +: TILE_ID_WIDTH];
    assign rd_idx  = rd_addr[REG_IDX_LSB +: REG_IDX_WIDTH];

    // a read enters the chain at the addressed tile
    assign load_mask = {{(NUM_TILES-1){1'b0}}, rd_en} << rd_tile;

    always_ff @(posedge clk) begin
        if (wr_clk_en && wr_en) begin
            cfg_mem[wr_tile][wr_idx] <= wr_data;
        end
    end

    // valid moves one tile toward tile 0 per enabled cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            chain_valid <= '0;
        end else if (rd_clk_en) begin
            chain_valid <= {1'b0, chain_valid[NUM_TILES-1:1]} | load_mask;
        end
    end

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_stage
        logic [AXI_DATA_WIDTH-1:0] upstream;

        if (k == NUM_TILES - 1) begin : g_last
            assign upstream = '0;
        end else begin : g_mid
            assign upstream = chain_data[k+1];
        end

        always_ff @(posedge clk) begin
            if (rd_clk_en) begin
                chain_data[k] <= load_mask[k] ? cfg_mem[k][rd_idx] : upstream;
            end
        end
    end

    assign rd_data       = chain_data[0];
    assign rd_data_valid = chain_valid[0];

endmodule

//--- design/glb_cfg_top.sv
// config front end only; the tile datapath is not part of this block
`timescale 1ns/1ps

module glb_cfg_top import glb_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [AXI_DATA_WIDTH-1:0] wdata,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [AXI_ADDR_WIDTH-1:0] araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                rresp,
    input  logic [NUM_TILES-1:0]      interrupt_event,
    output logic                      interrupt,
    output logic                      tile_wr_clk_en,
    output logic                      tile_rd_clk_en,
    output logic                      int_wr_clk_en,
    output logic                      int_rd_clk_en
);

    logic                      int_wr_en;
    logic [AXI_ADDR_WIDTH-1:0] int_wr_addr;
    logic [AXI_DATA_WIDTH-1:0] int_wr_data;
    logic                      int_rd_en;
    logic [AXI_ADDR_WIDTH-1:0] int_rd_addr;
    logic [AXI_DATA_WIDTH-1:0] int_rd_data;
    logic                      int_rd_data_valid;
    logic                      tile_wr_en;
    logic [AXI_ADDR_WIDTH-1:0] tile_wr_addr;
    logic [AXI_DATA_WIDTH-1:0] tile_wr_data;
    logic                      tile_rd_en;
    logic [AXI_ADDR_WIDTH-1:0] tile_rd_addr;
    logic [AXI_DATA_WIDTH-1:0] tile_rd_data;
    logic                      tile_rd_data_valid;

    glb_axil_cfg_ctrl u_ctrl (
        .clk                (clk),
        .reset              (reset),
        .awvalid            (awvalid),
        .awready            (awready),
        .awaddr             (awaddr),
        .wvalid             (wvalid),
        .wready             (wready),
        .wdata              (wdata),
        .bvalid             (bvalid),
        .bready             (bready),
        .bresp              (bresp),
        .arvalid            (arvalid),
        .arready            (arready),
        .araddr             (araddr),
        .rvalid             (rvalid),
        .rready             (rready),
        .rdata              (rdata),
        .rresp              (rresp),
        .int_wr_en          (int_wr_en),
        .int_wr_addr        (int_wr_addr),
        .int_wr_data        (int_wr_data),
        .int_rd_en          (int_rd_en),
        .int_rd_addr        (int_rd_addr),
        .int_rd_data        (int_rd_data),
        .int_rd_data_valid  (int_rd_data_valid),
        .int_wr_clk_en      (int_wr_clk_en),
        .int_rd_clk_en      (int_rd_clk_en),
        .tile_wr_en         (tile_wr_en),
        .tile_wr_addr       (tile_wr_addr),
        .tile_wr_data       (tile_wr_data),
        .tile_rd_en         (tile_rd_en),
        .tile_rd_addr       (tile_rd_addr),
        .tile_rd_data       (tile_rd_data),
        .tile_rd_data_valid (tile_rd_data_valid),
        .tile_wr_clk_en     (tile_wr_clk_en),
        .tile_rd_clk_en     (tile_rd_clk_en)
    );

    glb_interrupt_cfg u_interrupt (
        .clk             (clk),
        .reset           (reset),
        .wr_clk_en       (int_wr_clk_en),
        .rd_clk_en       (int_rd_clk_en),
        .wr_en           (int_wr_en),
        .wr_addr         (int_wr_addr),
        .wr_data         (int_wr_data),
        .rd_en           (int_rd_en),
        .rd_addr         (int_rd_addr),
        .interrupt_event (interrupt_event),
        .rd_data         (int_rd_data),
        .rd_data_valid   (int_rd_data_valid),
        .interrupt       (interrupt)
    );

    glb_tile_cfg u_tile (
        .clk           (clk),
        .reset         (reset),
        .wr_clk_en     (tile_wr_clk_en),
        .rd_clk_en     (tile_rd_clk_en),
        .wr_en         (tile_wr_en),
        .wr_addr       (tile_wr_addr),
        .wr_data       (tile_wr_data),
        .rd_en         (tile_rd_en),
        .rd_addr       (tile_rd_addr),
        .rd_data       (tile_rd_data),
        .rd_data_valid (tile_rd_data_valid)
    );

endmodule

//--- verification/glb_cfg_tb.sv
// one AXI-lite transaction at a time; stops at the first mismatch; run length bounded by table size
`timescale 1ns/1ps

module glb_cfg_tb import glb_cfg_pkg::*; ();

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_EVENT
    } op_t;

    localparam int RESET_CYCLES     = 10;
    localparam int CYCLES_PER_ENTRY = 40;

    logic                      clk;
    logic                      reset;
    logic                      awvalid;
    logic                      awready;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic                      wvalid;
    logic                      wready;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      bvalid;
    logic                      bready;
    logic [1:0]                bresp;
    logic                      arvalid;
    logic                      arready;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic                      rvalid;
    logic                      rready;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    logic [1:0]                rresp;
    logic [NUM_TILES-1:0]      interrupt_event;
    logic                      interrupt;
    logic                      tile_wr_clk_en;
    logic                      tile_rd_clk_en;
    logic                      int_wr_clk_en;
    logic                      int_rd_clk_en;

    // stimulus table, one column per queue
    string                     name_q  [$];
    op_t                       op_q    [$];
    logic [AXI_ADDR_WIDTH-1:0] addr_q  [$];
    logic [AXI_DATA_WIDTH-1:0] data_q  [$];
    int                        stall_q [$];
    logic [AXI_DATA_WIDTH-1:0] exp_q   [$];

    // register model
    logic [AXI_DATA_WIDTH-1:0] tile_model [NUM_TILES][REGS_PER_TILE];
    logic [NUM_TILES-1:0]      enable_model;
    logic [NUM_TILES-1:0]      status_model;

    integer seed = 69;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    glb_cfg_top UUT (
        .clk             (clk),
        .reset           (reset),
        .awvalid         (awvalid),
        .awready         (awready),
        .awaddr          (awaddr),
        .wvalid          (wvalid),
        .wready          (wready),
        .wdata           (wdata),
        .bvalid          (bvalid),
        .bready          (bready),
        .bresp           (bresp),
        .arvalid         (arvalid),
        .arready         (arready),
        .araddr          (araddr),
        .rvalid          (rvalid),
        .rready          (rready),
        .rdata           (rdata),
        .rresp           (rresp),
        .interrupt_event (interrupt_event),
        .interrupt       (interrupt),
        .tile_wr_clk_en  (tile_wr_clk_en),
        .tile_rd_clk_en  (tile_rd_clk_en),
        .int_wr_clk_en   (int_wr_clk_en),
        .int_rd_clk_en   (int_rd_clk_en)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run("timeout: the test table did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string msg);
        $display("%0s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [AXI_DATA_WIDTH-1:0] expected,
                                   input logic [AXI_DATA_WIDTH-1:0] actual);
        fail_run($sformatf("error %0s: expected 0x%08h, actual 0x%08h", name, expected, actual));
    endtask

    function automatic logic [AXI_ADDR_WIDTH-1:0] tile_addr(input int tile, input int idx);
        logic [AXI_ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[TILE_SEL_BIT] = 1'b1;
        addr[TILE_ID_LSB +: TILE_ID_WIDTH] = TILE_ID_WIDTH'(tile);
        addr[REG_IDX_LSB +: REG_IDX_WIDTH] = REG_IDX_WIDTH'(idx);
        return addr;
    endfunction

    // expected value is worked out from the model as the entry is added
    task automatic add_entry(input string name, input op_t op, input logic [AXI_ADDR_WIDTH-1:0] addr,
                             input logic [AXI_DATA_WIDTH-1:0] data, input int stall);
        logic [AXI_DATA_WIDTH-1:0] expected;
        logic [TILE_ID_WIDTH-1:0]  tile;
        logic [REG_IDX_WIDTH-1:0]  idx;
        tile = addr[TILE_ID_LSB +: TILE_ID_WIDTH];
        idx = addr[REG_IDX_LSB +: REG_IDX_WIDTH];
        expected = '0;
        case (op)
            OP_WRITE: begin
                if (addr[TILE_SEL_BIT]) begin
                    tile_model[tile][idx] = data;
                end else if (addr == INT_ENABLE_ADDR) begin
                    enable_model = data[NUM_TILES-1:0];
                end else if (addr == INT_STATUS_ADDR) begin
                    // write one to clear
                    status_model = status_model & ~data[NUM_TILES-1:0];
                end
                expected = 32'(|(status_model & enable_model));
            end
            OP_READ: begin
                if (addr[TILE_SEL_BIT]) begin
                    expected = tile_model[tile][idx];
                end else if (addr == INT_ENABLE_ADDR) begin
                    expected = 32'(enable_model);
                end else if (addr == INT_STATUS_ADDR) begin
                    expected = 32'(status_model);
                end else if (addr == INT_PENDING_ADDR) begin
                    expected = 32'(status_model & enable_model);
                end
            end
            default: begin
                status_model = status_model | data[NUM_TILES-1:0];
                expected = 32'(|(status_model & enable_model));
            end
        endcase
        name_q.push_back(name);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        stall_q.push_back(stall);
        exp_q.push_back(expected);
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < REGS_PER_TILE; r++) begin
                add_entry($sformatf("tile%0d_reg%0d_write", t, r), OP_WRITE, tile_addr(t, r),
                          $random(seed), (t + r) % 3);
            end
        end
        // read back in reverse, tile 3 with the longest stall
        for (int t = NUM_TILES - 1; t >= 0; t--) begin
            for (int r = 0; r < REGS_PER_TILE; r++) begin
                add_entry($sformatf("tile%0d_reg%0d_read", t, r), OP_READ, tile_addr(t, r),
                          '0, (t == NUM_TILES - 1) ? 5 : r);
            end
        end
        add_entry("int_enable_write", OP_WRITE, INT_ENABLE_ADDR, 32'hffff_fff5, 0);
        add_entry("int_enable_read", OP_READ, INT_ENABLE_ADDR, '0, 2);
        add_entry("int_pending_idle", OP_READ, INT_PENDING_ADDR, '0, 0);
        add_entry("int_unmapped_write", OP_WRITE, 12'h010, 32'hdead_beef, 0);
        add_entry("int_unmapped_read", OP_READ, 12'h010, '0, 1);
        add_entry("int_event_low", OP_EVENT, '0, 32'h3, 0);
        add_entry("int_status_low", OP_READ, INT_STATUS_ADDR, '0, 0);
        add_entry("int_pending_low", OP_READ, INT_PENDING_ADDR, '0, 0);
        add_entry("int_event_high", OP_EVENT, '0, 32'hc, 0);
        add_entry("int_status_all", OP_READ, INT_STATUS_ADDR, '0, 3);
        add_entry("int_clear_bit0", OP_WRITE, INT_STATUS_ADDR, 32'h1, 2);
        add_entry("int_status_no_bit0", OP_READ, INT_STATUS_ADDR, '0, 0);
        add_entry("int_clear_bit2", OP_WRITE, INT_STATUS_ADDR, 32'h4, 0);
        add_entry("int_status_no_bit2", OP_READ, INT_STATUS_ADDR, '0, 0);
        add_entry("int_pending_none", OP_READ, INT_PENDING_ADDR, '0, 0);
        add_entry("int_enable_bit3", OP_WRITE, INT_ENABLE_ADDR, 32'h8, 0);
        add_entry("int_pending_bit3", OP_READ, INT_PENDING_ADDR, '0, 0);
        add_entry("int_clear_all", OP_WRITE, INT_STATUS_ADDR, 32'hffff_ffff, 0);
        add_entry("int_status_empty", OP_READ, INT_STATUS_ADDR, '0, 0);
        add_entry("tile3_reg1_rewrite", OP_WRITE, tile_addr(3, 1), $random(seed), 5);
        add_entry("tile3_reg1_reread", OP_READ, tile_addr(3, 1), '0, 4);
        add_entry("tile0_reg2_reread", OP_READ, tile_addr(0, 2), '0, 0);
    endtask

    // the target not being accessed must keep its enables low
    task automatic check_isolation(input int i, input logic is_tile);
        if (is_tile) begin
            assert (!int_wr_clk_en && !int_rd_clk_en)
                else fail_run($sformatf("interrupt clock-enable high during %0s", name_q[i]));
        end else begin
            assert (!tile_wr_clk_en && !tile_rd_clk_en)
                else fail_run($sformatf("tile clock-enable high during %0s", name_q[i]));
        end
    endtask

    task automatic run_write(input int i);
        logic is_tile;
        logic aw_pend;
        logic w_pend;
        logic aw_hs;
        logic w_hs;
        is_tile = addr_q[i][TILE_SEL_BIT];
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr_q[i];
        wvalid  <= 1'b1;
        wdata   <= data_q[i];
        bready  <= 1'b0;
        aw_pend = 1'b1;
        w_pend = 1'b1;
        // sample just after the edge, the handshake lands on the next one
        while (aw_pend || w_pend) begin
            #1;
            aw_hs = awvalid && awready;
            w_hs = wvalid && wready;
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_pend = 1'b0;
            end
        end
        #1;
        while (!bvalid) begin
            check_isolation(i, is_tile);
            @(posedge clk);
            #1;
        end
        repeat (stall_q[i]) begin
            @(posedge clk);
            #1;
            assert (bvalid && bresp == AXI_RESP_OKAY)
                else fail_run($sformatf("write response changed under stall in %0s", name_q[i]));
            assert (is_tile ? tile_wr_clk_en : int_wr_clk_en)
                else fail_run($sformatf("write clock-enable dropped early in %0s", name_q[i]));
            check_isolation(i, is_tile);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        #1;
        assert (!bvalid)
            else fail_run($sformatf("bvalid still high after the handshake in %0s", name_q[i]));
        assert (32'(interrupt) == exp_q[i])
            else report_mismatch(name_q[i], exp_q[i], 32'(interrupt));
    endtask

    task automatic run_read(input int i);
        logic                      is_tile;
        logic [AXI_DATA_WIDTH-1:0] captured;
        is_tile = addr_q[i][TILE_SEL_BIT];
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr_q[i];
        rready  <= 1'b0;
        #1;
        while (!arready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        arvalid <= 1'b0;
        #1;
        while (!rvalid) begin
            check_isolation(i, is_tile);
            @(posedge clk);
            #1;
        end
        captured = rdata;
        repeat (stall_q[i]) begin
            @(posedge clk);
            #1;
            assert (rvalid && rdata == captured && rresp == AXI_RESP_OKAY)
                else fail_run($sformatf("read response changed under stall in %0s", name_q[i]));
            assert (is_tile ? tile_rd_clk_en : int_rd_clk_en)
                else fail_run($sformatf("read clock-enable dropped early in %0s", name_q[i]));
            check_isolation(i, is_tile);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        #1;
        assert (!rvalid)
            else fail_run($sformatf("rvalid still high after the handshake in %0s", name_q[i]));
        assert (captured == exp_q[i])
            else report_mismatch(name_q[i], exp_q[i], captured);
    endtask

    // one-cycle event pulse, then look at the interrupt line
    task automatic pulse_event(input int i);
        @(posedge clk);
        interrupt_event <= data_q[i][NUM_TILES-1:0];
        @(posedge clk);
        interrupt_event <= '0;
        @(posedge clk);
        #1;
        assert (32'(interrupt) == exp_q[i])
            else report_mismatch(name_q[i], exp_q[i], 32'(interrupt));
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        awvalid         = 1'b0;
        awaddr          = '0;
        wvalid          = 1'b0;
        wdata           = '0;
        bready          = 1'b0;
        arvalid         = 1'b0;
        araddr          = '0;
        rready          = 1'b0;
        interrupt_event = '0;
        enable_model    = '0;
        status_model    = '0;
        build_table();
        cycle_limit = RESET_CYCLES + name_q.size() * CYCLES_PER_ENTRY;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        #1;
        assert (awready && wready && arready && !bvalid && !rvalid && !interrupt)
            else fail_run("AXI handshake outputs or interrupt not at their reset values");
        assert (!tile_wr_clk_en && !tile_rd_clk_en && !int_wr_clk_en && !int_rd_clk_en)
            else fail_run("a clock-enable is high right after reset");
        for (int i = 0; i < name_q.size(); i++) begin
            case (op_q[i])
                OP_WRITE: run_write(i);
                OP_READ:  run_read(i);
                default:  pulse_event(i);
            endcase
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- src.f
design/glb_cfg_pkg.sv
design/glb_axil_cfg_ctrl.sv
design/glb_interrupt_cfg.sv
design/glb_tile_cfg.sv
design/glb_cfg_top.sv
verification/glb_cfg_tb.sv

//--- Makefile
TOP := glb_cfg_tb

.PHONY: all lint clean

all:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
